/* files.f */
rtl/led_pkg.sv
rtl/led_pattern.sv
rtl/led_frame_buf.sv
rtl/led_shift.sv
rtl/led_top.sv
tb/led_tb.sv

/* rtl/led_frame_buf.sv */
module led_frame_buf (
	input  logic                clk,
	input  logic                rst,
	input  led_pkg::led_frame_t frame,
	input  logic                done,
	output led_pkg::led_frame_t out
);

	logic                        pend;      // A vector waits for the serializer.
	logic [led_pkg::led_num-1:0] pend_leds;
	logic                        busy;      // Serializer is shifting a frame.
	logic                        idle;
	logic                        start;

	// The serializer is free again in its done cycle.
	assign idle  = !busy || done;
	assign start = idle && (pend || frame.upd);

	// The newest vector always replaces an older one still waiting.
	always_ff @(posedge clk) begin
		if (frame.upd) begin
			pend_leds <= frame.leds;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			busy <= 1'b0;
			out  <= '0;
		end else begin
			out.upd <= start;
			if (start) begin
				out.leds <= frame.upd ? frame.leds : pend_leds;
			end
			pend <= (pend || frame.upd) && !start;
			if (start) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

/* rtl/led_pattern.sv */
module led_pattern #(
	parameter int spark_max = 15_000_000,
	parameter int bling_max = 3,
	parameter int cnt_w     = 25
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                vld,
	input  led_pkg::led_cfg_u   cfg,
	input  logic [3:0]          bling_tick,
	output led_pkg::led_frame_t frame
);

	localparam logic [cnt_w-1:0] spark_lim = cnt_w'(spark_max);
	localparam logic [cnt_w-1:0] bling_lim = cnt_w'(bling_max);
	localparam logic [cnt_w-1:0] cnt_one   = cnt_w'(1);

	led_pkg::led_cfg_u cfg_q; // Word seen in the previous cycle.

	logic [led_pkg::led_num-1:0] hit;     // Counter reached its limit this cycle.
	logic [led_pkg::led_num-1:0] led_nxt; // State vector to load on vld.

	always_ff @(posedge clk) begin
		cfg_q <= cfg;
	end

	for (genvar i = 0; i < led_pkg::led_num; i++) begin : g_led

		// Only LEDs 2 to 5 have a tick input.
		localparam bit bling_ok = (i >= 2) && (i <= 5);

		led_pkg::led_mode_e mode;
		logic               change;
		logic               tick;
		logic               is_bling;
		logic               cycle;
		logic               run;
		logic [cnt_w-1:0]   lim;
		logic [cnt_w-1:0]   step;
		logic [cnt_w-1:0]   cnt;

		assign mode = cfg.mode[i];

		// A nibble that differs from last cycle restarts the blink phase.
		assign change = cfg.raw[4*i +: 4] != cfg_q.raw[4*i +: 4];

		if (bling_ok) begin : g_tick
			assign tick = bling_tick[i-2];
		end else begin : g_no_tick
			assign tick = 1'b0;
		end

		assign is_bling = bling_ok && (mode == led_pkg::mode_bling);

		// Modes that reload the counter on a hit and keep blinking.
		assign cycle = (mode == led_pkg::mode_spark1) || is_bling;

		// Any other code leaves the counter frozen.
		assign run = (mode == led_pkg::mode_spark) || cycle;

		assign lim = is_bling ? bling_lim : spark_lim;

		// In bling mode the counter moves only on its tick.
		assign step = is_bling ? {{(cnt_w-1){1'b0}}, tick} : cnt_one;

		assign hit[i] = run && (cnt == lim);

		always_ff @(posedge clk) begin
			if (rst) begin
				cnt <= '0;
			end else if (vld && (mode == led_pkg::mode_off || mode == led_pkg::mode_on)) begin
				cnt <= '0;
			end else if (vld && (mode == led_pkg::mode_spark || (cycle && change))) begin
				cnt <= cnt_one;
			end else if (hit[i]) begin
				// A single spark ends here, the blinking modes start a new period.
				cnt <= (mode == led_pkg::mode_spark) ? '0 : cnt_one;
			end else if (run && cnt != '0) begin
				cnt <= cnt + step;
			end
		end

		// Off clears and on or spark light the LED. Everything else keeps it.
		assign led_nxt[i] = (mode == led_pkg::mode_off)   ? 1'b0 :
		                    (mode == led_pkg::mode_on)    ? 1'b1 :
		                    (mode == led_pkg::mode_spark) ? 1'b1 :
		                    frame.leds[i];

	end

	// The state vector is loaded on a write and toggled on limit hits.
	// A write in the same cycle as a hit takes priority.
	always_ff @(posedge clk) begin
		if (rst) begin
			frame <= '0;
		end else begin
			frame.upd <= vld || (|hit);
			if (vld) begin
				frame.leds <= led_nxt;
			end else if (|hit) begin
				frame.leds <= frame.leds ^ hit;
			end
		end
	end

endmodule

/* rtl/led_pkg.sv */
package led_pkg;

	// Eight indicator LEDs sit on the external shift register.
	localparam int led_num = 8;

	// Per-LED mode codes. Codes 5 to 15 hold the current state and do not count.
	typedef enum logic [3:0] {
		mode_off    = 4'd0,
		mode_on     = 4'd1,
		mode_spark  = 4'd2, // One flash, then dark.
		mode_spark1 = 4'd3, // Steady blinking.
		mode_bling  = 4'd4  // Blinking on external ticks, LEDs 2 to 5 only.
	} led_mode_e;

	// The host mode word.
	// The raw view feeds the nibble change detection.
	// The mode view is used for decoding, with LED 0 in the lowest nibble.
	typedef union packed {
		logic [31:0]                 raw;
		led_mode_e [led_num-1:0]     mode;
	} led_cfg_u;

	// One LED state vector on its way to the serializer.
	typedef struct packed {
		logic               upd;  // High for one cycle with a new vector.
		logic [led_num-1:0] leds; // Bit 7 is LED 7.
	} led_frame_t;

endpackage

/* rtl/led_shift.sv */
module led_shift #(
	parameter int shift_half = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  led_pkg::led_frame_t load,
	output logic                done,
	output logic                sft_shcp,
	output logic                sft_ds
);

	localparam int hc_w = (shift_half > 1) ? $clog2(shift_half) : 1;
	localparam int bc_w = $clog2(led_pkg::led_num);

	localparam logic [hc_w-1:0] hc_last = hc_w'(shift_half - 1);
	localparam logic [bc_w-1:0] bc_last = bc_w'(led_pkg::led_num - 1);

	logic                        busy;
	logic [hc_w-1:0]             hc;   // Cycle within the half period.
	logic [bc_w-1:0]             bc;   // Bit being sent.
	logic [led_pkg::led_num-1:0] sreg;
	logic                        half_end;

	assign half_end = hc == hc_last;

	// Last cycle of the high half of the last bit.
	assign done = busy && sft_shcp && half_end && (bc == bc_last);

	// MSB leaves first, zeros fill in from the bottom.
	always_ff @(posedge clk) begin
		if (!busy && load.upd) begin
			sreg <= load.leds;
		end else if (busy && sft_shcp && half_end) begin
			sreg <= {sreg[led_pkg::led_num-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			hc       <= '0;
			bc       <= '0;
			sft_shcp <= 1'b0;
			sft_ds   <= 1'b0;
		end else if (!busy) begin
			if (load.upd) begin
				busy     <= 1'b1;
				hc       <= '0;
				bc       <= '0;
				sft_shcp <= 1'b0;
				sft_ds   <= load.leds[led_pkg::led_num-1];
			end
		end else if (!half_end) begin
			hc <= hc + 1'b1;
		end else begin
			hc       <= '0;
			sft_shcp <= !sft_shcp;
			if (sft_shcp) begin
				// Next bit goes on the line while the clock is low.
				sft_ds <= sreg[led_pkg::led_num-2];
				bc     <= bc + 1'b1;
				if (bc == bc_last) begin
					busy <= 1'b0;
				end
			end
		end
	end

endmodule

/* rtl/led_top.sv */
module led_top #(
	parameter int spark_max  = 15_000_000,
	parameter int bling_max  = 3,
	parameter int shift_half = 4,
	parameter int cnt_w      = 25
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              vld,
	input  led_pkg::led_cfg_u cfg,
	input  logic [3:0]        bling_tick,
	output logic              sft_shcp,
	output logic              sft_ds
);

	led_pkg::led_frame_t frame; // Pattern block to frame buffer.
	led_pkg::led_frame_t out;   // Frame buffer to serializer.
	logic                done;

	led_pattern #(
		.spark_max (spark_max),
		.bling_max (bling_max),
		.cnt_w     (cnt_w)
	) u_pattern (
		.clk        (clk),
		.rst        (rst),
		.vld        (vld),
		.cfg        (cfg),
		.bling_tick (bling_tick),
		.frame      (frame)
	);

	led_frame_buf u_frame_buf (
		.clk   (clk),
		.rst   (rst),
		.frame (frame),
		.done  (done),
		.out   (out)
	);

	led_shift #(
		.shift_half (shift_half)
	) u_shift (
		.clk      (clk),
		.rst      (rst),
		.load     (out),
		.done     (done),
		.sft_shcp (sft_shcp),
		.sft_ds   (sft_ds)
	);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the LED controller testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module led_tb \
	-f files.f \
	-o led_sim

./obj_dir/led_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"

/* tb/led_tb.sv */
module led_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int spark_max  = 200;
	localparam int bling_max  = 3;
	localparam int shift_half = 2;
	localparam int timeout_cycles = 20_000; // The tests take about 4,000 cycles.

	typedef struct packed {
		logic [7:0] leds;
		int         cyc;  // Cycle in which the last bit was clocked in.
	} rx_frame_t;

	logic              clk = 1'b0;
	logic              rst;
	logic              vld;
	led_pkg::led_cfg_u cfg;
	logic [3:0]        bling_tick;
	logic              sft_shcp;
	logic              sft_ds;

	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	logic [31:0] lfsr_state = 32'd98808;
	rx_frame_t   rx_q[$];
	logic        shcp_q;
	logic [7:0]  shift_in;
	int          bit_cnt;

	led_top #(
		.spark_max  (spark_max),
		.bling_max  (bling_max),
		.shift_half (shift_half)
	) dut0 (
		.clk        (clk),
		.rst        (rst),
		.vld        (vld),
		.cfg        (cfg),
		.bling_tick (bling_tick),
		.sft_shcp   (sft_shcp),
		.sft_ds     (sft_ds)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= timeout_cycles) begin
			$display("Run stopped at cycle %0d before the tests finished, %0d checks done, %0d errors",
			         cyc, checks, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	// The shift register takes sft_ds on each rising edge of sft_shcp.
	always @(posedge clk) begin
		if (rst) begin
			shcp_q  <= 1'b0;
			bit_cnt <= 0;
		end else begin
			shcp_q <= sft_shcp;
			if (sft_shcp && !shcp_q) begin
				shift_in <= {shift_in[6:0], sft_ds};
				if (bit_cnt == 7) begin
					rx_q.push_back(rx_frame_t'{leds: {shift_in[6:0], sft_ds}, cyc: cyc});
					bit_cnt <= 0;
				end else begin
					bit_cnt <= bit_cnt + 1;
				end
			end
		end
	end

	// Taps 32, 22, 2 and 1, new bit enters at the bottom.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic draw_bit();
		lfsr_state = lfsr_next(lfsr_state);
		return lfsr_state[0];
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s: expected 0x%02h, actual 0x%02h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		checks++;
		assert (got == exp) else begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_range(input string name, input int lo, input int hi, input int got);
		checks++;
		assert (got >= lo && got <= hi) else begin
			$display("[ERROR] %s: expected %0d to %0d, actual %0d", name, lo, hi, got);
			errors++;
		end
	endtask

	task automatic check_cond(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic write_cfg(input logic [31:0] word);
		@(negedge clk);
		cfg.raw = word;
		vld     = 1'b1;
		@(negedge clk);
		vld = 1'b0;
	endtask

	task automatic wait_frames(input int n, input int limit, output bit ok);
		int waited;
		waited = 0;
		while (rx_q.size() < n && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		ok = rx_q.size() >= n;
	endtask

	task automatic reset_and_static();
		bit ok;
		ok = 1'b1;
		for (int k = 0; k < 50; k++) begin
			@(negedge clk);
			if (sft_shcp !== 1'b0 || sft_ds !== 1'b0) ok = 1'b0;
		end
		check_cond(ok, "reset_and_static: shift outputs moved with no mode write");
		check_count("reset_and_static idle frames", 0, rx_q.size());
		write_cfg(32'h0000_1111); // LEDs 0 to 3 on.
		wait_frames(1, 100, ok);
		check_cond(ok, "reset_and_static: no frame after the mode write");
		idle_cycles(50);
		check_count("reset_and_static frames", 1, rx_q.size());
		if (ok) check_byte("reset_and_static", 8'h0f, rx_q[0].leds);
	endtask

	task automatic random_off_on();
		bit          ok;
		logic        b;
		logic [31:0] word;
		logic [7:0]  mask;
		for (int w = 0; w < 20; w++) begin
			word = '0;
			mask = '0;
			for (int i = 0; i < 8; i++) begin
				b             = draw_bit();
				mask[i]       = b;
				word[4*i +: 4] = b ? 4'd1 : 4'd0;
			end
			rx_q.delete();
			write_cfg(word);
			wait_frames(1, 100, ok);
			check_cond(ok, "random_off_on: a mode write gave no frame");
			if (ok) check_byte("random_off_on", mask, rx_q[0].leds);
		end
	endtask

	task automatic single_spark();
		bit ok;
		int gap;
		idle_cycles(10);
		rx_q.delete();
		write_cfg(32'h0020_0000);
		wait_frames(2, spark_max + 200, ok);
		check_cond(ok, "single_spark: the lit and the dark frame did not both arrive");
		if (ok) begin
			check_byte("single_spark lit", 8'h20, rx_q[0].leds);
			check_byte("single_spark dark", 8'h00, rx_q[1].leds);
			gap = rx_q[1].cyc - rx_q[0].cyc;
			check_range("single_spark dark delay", spark_max, spark_max + 64, gap);
		end
	endtask

	task automatic steady_blink();
		bit ok;
		int gap;
		rx_q.delete();
		write_cfg(32'h0000_0000);
		wait_frames(1, 100, ok);
		idle_cycles(5);
		rx_q.delete();
		write_cfg(32'h0000_0030);
		wait_frames(5, 1000, ok); // The write frame and four toggles.
		check_cond(ok, "steady_blink: fewer than four toggle frames in 1000 cycles");
		if (ok) begin
			for (int k = 0; k < 5; k++) begin
				check_byte("steady_blink", (k % 2 == 1) ? 8'h02 : 8'h00, rx_q[k].leds);
			end
			// The same word again lands halfway through a period.
			idle_cycles(60);
			write_cfg(32'h0000_0030);
			wait_frames(7, spark_max + 200, ok);
			check_cond(ok, "steady_blink: frames missing after the repeated write");
			if (ok) begin
				check_byte("steady_blink rewrite", 8'h00, rx_q[5].leds);
				check_byte("steady_blink toggle", 8'h02, rx_q[6].leds);
				gap = rx_q[6].cyc - rx_q[4].cyc;
				check_range("steady_blink period after rewrite", spark_max - 3, spark_max + 1,
				            gap);
			end
		end
	endtask

	task automatic tick_blink();
		bit ok;
		rx_q.delete();
		write_cfg(32'h0000_4000);
		wait_frames(1, 100, ok);
		check_cond(ok, "tick_blink: the mode write gave no frame");
		if (ok) check_byte("tick_blink write", 8'h00, rx_q[0].leds);
		idle_cycles(300);
		check_count("tick_blink frames without ticks", 1, rx_q.size());
		rx_q.delete();
		for (int k = 0; k < 6; k++) begin
			@(negedge clk);
			bling_tick = 4'b0010; // Tick for LED 3.
			@(negedge clk);
			bling_tick = 4'b0000;
			idle_cycles(50);
		end
		idle_cycles(100);
		check_count("tick_blink frames", 3, rx_q.size());
		if (rx_q.size() == 3) begin
			check_byte("tick_blink 1", 8'h08, rx_q[0].leds);
			check_byte("tick_blink 2", 8'h00, rx_q[1].leds);
			check_byte("tick_blink 3", 8'h08, rx_q[2].leds);
		end
	endtask

	task automatic frame_overwrite();
		bit ok;
		rx_q.delete();
		write_cfg(32'h1111_0000);
		idle_cycles(1);
		write_cfg(32'h0101_0101);
		wait_frames(2, 150, ok);
		idle_cycles(50);
		check_cond(rx_q.size() > 0, "frame_overwrite: no frame arrived after two writes");
		check_cond(rx_q.size() <= 2, "frame_overwrite: more than two frames for two writes");
		if (rx_q.size() > 0) check_byte("frame_overwrite last", 8'h55, rx_q[$].leds);
	endtask

	initial begin
		rst        = 1'b1;
		vld        = 1'b0;
		cfg.raw    = '0;
		bling_tick = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		reset_and_static();
		random_off_on();
		single_spark();
		steady_blink();
		tick_blink();
		frame_overwrite();
		$display("%0d checks done, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
